//--- tests/counterTrace.txt
# idle(dec) events(hex) wr adr priv(0 user 1 super 3 machine) wval expRead(reads only) illegal
# event bits b0 valid b4-1 class b5 bpWrong b6 exc b7 irq b8-11 cache b12 ldStall b13 stStall
# b14 stallE b15 stallM b16 flushM held through idle and op cycles
9  00000 0 B00 3 00000000 00000009 0
0  00000 0 C01 3 00000000 00000002 0
20 00000 0 C01 3 00000000 00000007 0
0  00000 0 C81 3 00000000 00000000 0
0  00000 0 B01 3 00000000 00000000 1
0  00000 0 B81 3 00000000 00000000 1
0  00000 1 B00 3 00000000 00000000 0
12 00000 0 B00 3 00000000 0000000C 0
0  00000 1 B00 3 FFFFFFF0 00000000 0
20 00000 0 B80 3 00000000 00000001 0
0  00000 0 B00 3 00000000 00000005 0
0  00000 1 320 3 00000001 00000000 0
0  00000 1 B00 3 00000100 00000000 0
10 00000 0 B00 3 00000000 00000100 0
0  00000 0 320 3 00000000 00000001 0
0  00000 1 320 3 00000000 00000000 0
3  00000 0 B00 3 00000000 00000103 0
5  00003 0 B02 3 00000000 00000005 0
0  00000 0 B03 3 00000000 00000006 0
3  00005 0 B04 3 00000000 00000003 0
4  0000D 0 B05 3 00000000 00000004 0
0  00000 0 B04 3 00000000 00000004 0
6  0007E 0 B02 3 00000000 0000000F 0
0  00000 0 B03 3 00000000 00000006 0
0  00000 0 B0D 3 00000000 00000007 0
7  01000 0 B08 3 00000000 00000000 0
2  00000 0 B07 3 00000000 00000008 0
7  11000 0 B08 3 00000000 00000000 0
2  10000 0 B07 3 00000000 00000008 0
0  00000 0 C00 0 00000000 00000000 1
0  00000 1 306 3 00000001 00000000 0
0  00000 0 C00 0 00000000 00000000 1
0  00000 0 C00 1 00000000 00000137 0
0  00000 1 106 1 00000001 00000000 0
0  00000 0 C00 0 00000000 00000139 0
0  00000 0 B00 1 00000000 00000000 1
0  00000 1 C00 3 00000000 00000000 1
0  00000 0 B00 3 00000000 0000013C 0
0  00000 0 C80 0 00000000 00000001 0
0  00000 0 7C0 3 00000000 00000000 1
0  00000 1 320 1 0000FFFF 00000000 1
0  00000 0 320 3 00000000 00000000 0
0  00000 1 306 0 00000005 00000000 1
0  00000 0 306 3 00000000 00000001 0
0  00000 0 106 3 00000000 00000001 0
0  00000 1 106 3 0000ABCD 00000000 0
0  00000 0 106 3 00000000 0000ABCD 0
0  00000 1 320 3 00000008 00000000 0
0  00000 0 320 3 00000000 00000008 0

//--- counterCsrUnit.f
+incdir+tests
common/counterPkg.sv
design/timeBase.sv
design/eventPipe.sv
csr/csrCounters.sv
csr/csrControl.sv
design/counterCsrUnit.sv
tests/tbCounterCsr.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= tbCounterCsr
RTL_TOP     ?= counterCsrUnit
FILELIST    ?= counterCsrUnit.f
OBJDIR      ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert
LINT_FLAGS  ?= --lint-only --timing
PASS_TEXT   ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- tests/tbTasks.svh
// trace line parser, value check and failure stop for the counter CSR testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// report the cause then stop with an error status
task automatic stopRun(input string why);
  $display("%s", why);
  $display("SOME TESTS FAILED");
  $fatal(1, "simulation stopped");
endtask

// compare one observed value with the expected one
task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
  if (got !== want) begin
    failures++;
    stopRun($sformatf("error %s got %h expected %h", name, got, want));
  end
endtask

// split one trace line into its columns
task automatic parseLine(input string text, output bit isData, output int idle,
                         output logic [16:0] ev, output logic wr, output logic [11:0] adr,
                         output logic [1:0] priv, output logic [31:0] wval,
                         output logic [31:0] expVal, output logic ill);
  int n;
  isData = 1'b0;
  if (text.len() > 1 && text[0] != "#") begin   // comment and blank lines carry no data
    n = $sscanf(text, "%d %h %h %h %h %h %h %h", idle, ev, wr, adr, priv, wval, expVal, ill);
    if (n == 8) isData = 1'b1;
    else stopRun($sformatf("trace line has %0d readable columns instead of 8: %s", n, text));
  end
endtask

`endif

//--- tests/tbCounterCsr.sv
// testbench that replays the counter trace against the counter CSR unit
`timescale 1ns/10ps

module tbCounterCsr;

  localparam int HALF_PERIOD  = 50;   // 100 ns clock
  localparam int RESET_CYCLES = 16;
  localparam int MARGIN       = 50;   // spare cycles before the timeout
  localparam int SAMPLE_DELAY = 25;   // outputs settled well before the next rising edge

  logic        clk;
  logic        reset;
  logic        stallE, stallM, flushM;
  logic        loadStallD, storeStallD;
  logic        instrValid;
  logic [3:0]  instrClass;
  logic        bpWrong, exception, interrupt;
  logic        dCacheAccess, dCacheMiss, iCacheAccess, iCacheMiss;
  logic [11:0] csrAdr;
  logic        csrWrite;
  logic [31:0] csrWriteVal;
  logic [1:0]  privMode;
  logic [31:0] csrReadVal;      // combinational read data
  logic        csrIllegal;

  // trace columns
  int          idleQ[$];
  logic [16:0] evQ[$];
  logic        wrQ[$];
  logic [11:0] adrQ[$];
  logic [1:0]  privQ[$];
  logic [31:0] wvalQ[$];
  logic [31:0] expQ[$];        // checked on reads only
  logic        illQ[$];

  int failures;
  int cycles;
  int cycleLimit;               // zero until the trace is loaded

  `include "tbTasks.svh"

  counterCsrUnit #(
    .XLEN(32), .COUNTERS(16), .S_SUPPORTED(1), .HPM_SUPPORTED(1), .TICK_DIV(4)
  ) dut (
    .clk, .reset, .stallE, .stallM, .flushM, .loadStallD, .storeStallD,
    .instrValid, .instrClass, .bpWrong, .exception, .interrupt,
    .dCacheAccess, .dCacheMiss, .iCacheAccess, .iCacheMiss,
    .csrAdr, .csrWrite, .csrWriteVal, .privMode, .csrReadVal, .csrIllegal
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  //////////////////////////////
  // timeout
  always @(posedge clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles > cycleLimit)
      stopRun($sformatf("timeout after %0d cycles because the trace did not finish", cycles));
  end

  //////////////////////////////
  // stimulus
  task automatic applyEvents(input logic [16:0] ev);
    instrValid   = ev[0];
    instrClass   = ev[4:1];   // branch jump return spare
    bpWrong      = ev[5];
    exception    = ev[6];
    interrupt    = ev[7];
    dCacheAccess = ev[8];
    dCacheMiss   = ev[9];
    iCacheAccess = ev[10];
    iCacheMiss   = ev[11];
    loadStallD   = ev[12];
    storeStallD  = ev[13];
    stallE       = ev[14];
    stallM       = ev[15];
    flushM       = ev[16];
  endtask

  task automatic readTrace();
    int          fd;
    string       text;
    bit          isData;
    int          idle;
    logic [16:0] ev;
    logic        wr, ill;
    logic [11:0] adr;
    logic [1:0]  priv;
    logic [31:0] wval, expVal;
    fd = $fopen("tests/counterTrace.txt", "r");
    if (fd == 0) begin
      stopRun("cannot open the trace file tests/counterTrace.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(text, fd) != 0) begin
          parseLine(text, isData, idle, ev, wr, adr, priv, wval, expVal, ill);
          if (isData) begin
            idleQ.push_back(idle);
            evQ.push_back(ev);
            wrQ.push_back(wr);
            adrQ.push_back(adr);
            privQ.push_back(priv);
            wvalQ.push_back(wval);
            expQ.push_back(expVal);
            illQ.push_back(ill);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // idle cycles with the events held then one CSR access with events still held
  task automatic runLine(input int i);
    applyEvents(evQ[i]);
    csrWrite    = 1'b0;   // bus quiet during idle cycles
    csrAdr      = 12'h000;
    csrWriteVal = '0;
    privMode    = 2'd3;
    repeat (idleQ[i]) @(negedge clk);
    csrAdr      = adrQ[i];
    csrWrite    = wrQ[i];
    csrWriteVal = wvalQ[i];
    privMode    = privQ[i];
    #SAMPLE_DELAY;
    if (!wrQ[i]) checkValue($sformatf("csrReadVal at trace op %0d", i), csrReadVal, expQ[i]);
    checkValue($sformatf("csrIllegal at trace op %0d", i), {31'b0, csrIllegal},
               {31'b0, illQ[i]});
    @(negedge clk);      // write lands on the edge in between
  endtask

  initial begin
    reset       = 1'b1;
    applyEvents(17'h0);
    csrAdr      = 12'h000;
    csrWrite    = 1'b0;
    csrWriteVal = '0;
    privMode    = 2'd3;
    failures    = 0;
    cycles      = 0;
    cycleLimit  = 0;
    readTrace();
    foreach (idleQ[i]) cycleLimit += idleQ[i] + 1;
    cycleLimit += RESET_CYCLES + MARGIN;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;        // trace cycle 0 starts here
    foreach (idleQ[i]) runLine(i);
    if (failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- design/counterCsrUnit.sv
// top level joining timer, event pipe, counters and count control
`timescale 1ns/10ps

module counterCsrUnit import counterPkg::*; #(
  parameter int XLEN          = 32,
  parameter int COUNTERS      = 16,
  parameter int S_SUPPORTED   = 1,
  parameter int HPM_SUPPORTED = 1,
  parameter int TICK_DIV      = 1
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            stallE,
  input  logic            stallM,
  input  logic            flushM,
  input  logic            loadStallD,
  input  logic            storeStallD,
  input  logic            instrValid,
  input  logic [3:0]      instrClass,
  input  logic            bpWrong,
  input  logic            exception,
  input  logic            interrupt,
  input  logic            dCacheAccess,
  input  logic            dCacheMiss,
  input  logic            iCacheAccess,
  input  logic            iCacheMiss,
  input  csrAddrT         csrAdr,
  input  logic            csrWrite,
  input  logic [XLEN-1:0] csrWriteVal,
  input  privT            privMode,
  output logic [XLEN-1:0] csrReadVal,
  output logic            csrIllegal
);

  logic [63:0]         mtime;
  logic [COUNTERS-1:0] counterEvent;
  logic [31:0]         countInhibit, countEn, sCountEn;
  logic                writeLegal;
  logic                cntHit, cntDenied;
  logic [XLEN-1:0]     cntReadVal;

  timeBase #(.TICK_DIV(TICK_DIV)) timer (
    .clk, .reset, .mtime
  );

  eventPipe #(.COUNTERS(COUNTERS), .HPM_SUPPORTED(HPM_SUPPORTED)) events (
    .clk, .reset, .stallE, .stallM, .flushM, .loadStallD, .storeStallD,
    .instrValid, .instrClass, .bpWrong, .exception, .interrupt,
    .dCacheAccess, .dCacheMiss, .iCacheAccess, .iCacheMiss, .counterEvent
  );

  csrCounters #(.XLEN(XLEN), .COUNTERS(COUNTERS), .S_SUPPORTED(S_SUPPORTED)) counters (
    .clk, .reset, .csrAdr, .csrWriteVal, .writeLegal, .privMode,
    .countInhibit, .countEn, .sCountEn, .counterEvent, .mtime,
    .cntReadVal, .cntHit, .cntDenied
  );

  csrControl #(.XLEN(XLEN), .S_SUPPORTED(S_SUPPORTED)) control (
    .clk, .reset, .csrAdr, .csrWrite, .csrWriteVal, .privMode,
    .cntHit, .cntDenied, .cntReadVal, .writeLegal,
    .countInhibit, .countEn, .sCountEn, .csrReadVal, .csrIllegal
  );

endmodule

//--- csr/csrControl.sv
// count control registers, write legality and the final CSR read mux
`timescale 1ns/10ps

module csrControl import counterPkg::*; #(
  parameter int XLEN        = 32,
  parameter int S_SUPPORTED = 1
) (
  input  logic            clk,
  input  logic            reset,
  input  csrAddrT         csrAdr,
  input  logic            csrWrite,
  input  logic [XLEN-1:0] csrWriteVal,
  input  privT            privMode,
  input  logic            cntHit,
  input  logic            cntDenied,
  input  logic [XLEN-1:0] cntReadVal,
  output logic            writeLegal,
  output logic [31:0]     countInhibit,
  output logic [31:0]     countEn,
  output logic [31:0]     sCountEn,
  output logic [XLEN-1:0] csrReadVal,
  output logic            csrIllegal
);

  logic privOk;            // mode is high enough for this address
  logic roWrite;           // write aimed at a read-only CSR
  logic hitInhibit, hitMEn, hitSEn;
  logic ctlHit;
  logic [31:0] ctlVal;

  assign privOk     = (csrAdr.f.lowPriv <= privMode);
  assign roWrite    = csrWrite && (csrAdr.f.access == 2'b11);
  assign writeLegal = csrWrite && privOk && !roWrite;

  assign hitInhibit = (csrAdr.raw == MCOUNTINHIBIT);
  assign hitMEn     = (csrAdr.raw == MCOUNTEREN);
  assign hitSEn     = (S_SUPPORTED != 0) && (csrAdr.raw == SCOUNTEREN);
  assign ctlHit     = hitInhibit || hitMEn || hitSEn;

  //////////////////////////////
  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      countInhibit <= '0;
      countEn      <= '0;
    end else if (writeLegal) begin
      if (hitInhibit) countInhibit <= csrWriteVal[31:0];
      if (hitMEn) countEn <= csrWriteVal[31:0];
    end
  end

  if (S_SUPPORTED != 0) begin : gSCountEn
    always_ff @(posedge clk) begin
      if (reset) sCountEn <= '0;
      else if (writeLegal && hitSEn) sCountEn <= csrWriteVal[31:0];
    end
  end else begin : gNoSCountEn
    assign sCountEn = '0;   // no supervisor mode
  end

  //////////////////////////////
  // final read
  assign ctlVal = hitInhibit ? countInhibit : (hitMEn ? countEn : sCountEn);

  assign csrIllegal = !privOk || roWrite || !(ctlHit || cntHit) || cntDenied;
  assign csrReadVal = csrIllegal ? '0 : (ctlHit ? XLEN'(ctlVal) : cntReadVal);

  // control and counter address ranges never overlap
  exclusiveClaim: assert property (@(posedge clk) disable iff (reset)
    !(ctlHit && cntHit));

endmodule

//--- csr/csrCounters.sv
// counter registers with their write path, inhibit and privilege-checked counter reads
`timescale 1ns/10ps

module csrCounters import counterPkg::*; #(
  parameter int XLEN        = 32,
  parameter int COUNTERS    = 16,
  parameter int S_SUPPORTED = 1
) (
  input  logic                clk,
  input  logic                reset,
  input  csrAddrT             csrAdr,
  input  logic [XLEN-1:0]     csrWriteVal,
  input  logic                writeLegal,
  input  privT                privMode,
  input  logic [31:0]         countInhibit,
  input  logic [31:0]         countEn,
  input  logic [31:0]         sCountEn,
  input  logic [COUNTERS-1:0] counterEvent,
  input  logic [63:0]         mtime,
  output logic [XLEN-1:0]     cntReadVal,
  output logic                cntHit,
  output logic                cntDenied
);

  logic [63:0]         cnt [COUNTERS];   // full 64-bit counters
  logic [COUNTERS-1:0] wrLo, wrHi;       // write strobes per counter
  logic [63:0]         cntSel;           // counter picked by the index
  logic [4:0]          cntNum;
  logic                inRange;
  logic                mLo, mHi, uLo, uHi;
  logic                loHit, hiHit;

  //////////////////////////////
  // counters
  for (genvar i = 0; i < COUNTERS; i++) begin : gCnt
    logic [63:0] cntPlus;

    assign cntPlus = cnt[i] + {63'b0, counterEvent[i] & ~countInhibit[i]};
    // slot 1 has no machine counter so it never takes a write
    assign wrLo[i] = writeLegal && (i != 1) && (csrAdr.raw == MHPMCOUNTER + 12'(i));

    if (XLEN == 32) begin : gHiWr
      assign wrHi[i] = writeLegal && (i != 1) && (csrAdr.raw == MHPMCOUNTERH + 12'(i));
    end else begin : gNoHiWr
      assign wrHi[i] = 1'b0;   // rv64 writes the whole counter at once
    end

    always_ff @(posedge clk) begin
      if (reset) cnt[i] <= '0;
      else begin
        cnt[i] <= cntPlus;
        if (wrLo[i]) cnt[i][XLEN-1:0] <= csrWriteVal;   // write wins over increment
        if (wrHi[i]) cnt[i][63:32] <= csrWriteVal[31:0];
      end
    end
  end

  //////////////////////////////
  // address decode
  assign cntNum  = csrAdr.f.index[4:0];
  assign inRange = (csrAdr.f.index[6:5] == 2'b00) && (int'(cntNum) < COUNTERS);

  assign mLo = (csrAdr.raw[11:7] == MHPMCOUNTER[11:7]);
  assign mHi = (csrAdr.raw[11:7] == MHPMCOUNTERH[11:7]);
  assign uLo = (csrAdr.raw[11:7] == HPMCOUNTER[11:7]);
  assign uHi = (csrAdr.raw[11:7] == HPMCOUNTERH[11:7]);

  // machine slot 1 would be mtime which lives outside the CSR space
  assign loHit = (mLo || uLo) && inRange && !(mLo && cntNum == 5'd1);
  assign hiHit = (XLEN == 32) && (mHi || uHi) && inRange && !(mHi && cntNum == 5'd1);
  assign cntHit = loHit || hiHit;

  always_comb begin
    cntSel = '0;
    for (int k = 0; k < COUNTERS; k++) begin
      if (cntNum == 5'(k)) cntSel = cnt[k];
    end
  end

  //////////////////////////////
  // read value and counteren check
  always_comb begin
    cntReadVal = '0;
    if (cntHit) begin
      if (csrAdr.raw == TIME) cntReadVal = mtime[XLEN-1:0];
      else if (csrAdr.raw == TIMEH) cntReadVal = XLEN'(mtime[63:32]);
      else if (hiHit) cntReadVal = XLEN'(cntSel[63:32]);   // upper half on rv32
      else cntReadVal = cntSel[XLEN-1:0];                  // value before this cycle's count
    end
  end

  always_comb begin
    case (privMode)
      PRIV_M:  cntDenied = 1'b0;
      PRIV_S:  cntDenied = cntHit && !countEn[cntNum];
      default: cntDenied = cntHit && (!countEn[cntNum] ||
                                      ((S_SUPPORTED != 0) && !sCountEn[cntNum]));   // user also needs scounteren
    endcase
  end

  // a single address can only strobe one counter half
  oneCntWrite: assert property (@(posedge clk) disable iff (reset)
    $onehot0({wrHi, wrLo}));

endmodule

//--- design/eventPipe.sv
// stall flag pipe from decode to memory stage and the per-counter event vector
`timescale 1ns/10ps

module eventPipe import counterPkg::*; #(
  parameter int COUNTERS      = 16,
  parameter int HPM_SUPPORTED = 1
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                stallE,
  input  logic                stallM,
  input  logic                flushM,
  input  logic                loadStallD,
  input  logic                storeStallD,
  input  logic                instrValid,
  input  logic [3:0]          instrClass,    // retire class bits
  input  logic                bpWrong,
  input  logic                exception,
  input  logic                interrupt,
  input  logic                dCacheAccess,
  input  logic                dCacheMiss,
  input  logic                iCacheAccess,
  input  logic                iCacheMiss,
  output logic [COUNTERS-1:0] counterEvent
);

  logic [1:0]  stallFlagE, stallFlagM;   // {store, load}
  logic [31:0] evAll;                    // full event slots before trimming

  //////////////////////////////
  // stall flags follow the instruction
  always_ff @(posedge clk) begin
    if (reset) stallFlagE <= '0;
    else if (!stallE) stallFlagE <= {storeStallD, loadStallD};
  end

  always_ff @(posedge clk) begin
    if (reset || flushM) stallFlagM <= '0;   // flushed instruction counts nothing
    else if (!stallM) stallFlagM <= stallFlagE;
  end

  //////////////////////////////
  // event vector
  always_comb begin
    evAll = '0;                      // slot 1 stays zero since time is not counted here
    evAll[EV_CYCLE]   = 1'b1;        // every clock
    evAll[EV_INSTRET] = instrValid;
    if (HPM_SUPPORTED != 0) begin
      evAll[EV_BRANCH]     = instrValid & instrClass[0];
      evAll[EV_JUMP]       = instrValid & instrClass[1] & ~instrClass[2];   // jumps that are not returns
      evAll[EV_RETURN]     = instrValid & instrClass[2];
      evAll[EV_BPWRONG]    = instrValid & bpWrong;
      evAll[EV_LOADSTALL]  = stallFlagM[0];
      evAll[EV_STORESTALL] = stallFlagM[1];
      evAll[EV_DACCESS]    = dCacheAccess;
      evAll[EV_DMISS]      = dCacheMiss;
      evAll[EV_IACCESS]    = iCacheAccess;
      evAll[EV_IMISS]      = iCacheMiss;
      evAll[EV_EXCEPT]     = exception;   // not tied to instrValid
      evAll[EV_INTERRUPT]  = interrupt;
    end
  end

  assign counterEvent = evAll[COUNTERS-1:0];   // only implemented counters

  // decode never flags a load and a store stall for the same instruction
  oneStallKind: assert property (@(posedge clk) disable iff (reset)
    !(stallFlagM[0] && stallFlagM[1]));

endmodule

//--- design/timeBase.sv
// free-running 64-bit machine timer with a clock prescaler
`timescale 1ns/10ps

module timeBase #(
  parameter int TICK_DIV = 1
) (
  input  logic        clk,
  input  logic        reset,
  output logic [63:0] mtime
);

  // prescaler needs at least one bit even when TICK_DIV is 1
  localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [PW-1:0] preCnt;   // clocks since last tick
  logic          tick;

  assign tick = (preCnt == PW'(TICK_DIV - 1));   // last clock of the period

  always_ff @(posedge clk) begin
    if (reset) preCnt <= '0;
    else if (tick) preCnt <= '0;                   // wrap
    else preCnt <= preCnt + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (reset) mtime <= '0;
    else if (tick) mtime <= mtime + 64'd1;         // one count per period
  end

  // timer only ever holds or steps by one between resets
  timerMonotonic: assert property (@(posedge clk) disable iff (reset)
    !reset |=> (mtime == $past(mtime)) || (mtime == $past(mtime) + 64'd1));

endmodule

//--- common/counterPkg.sv
// privilege codes, CSR address constants, counter event indices and the CSR address union
package counterPkg;

  //////////////////////////////
  // privilege modes
  typedef logic [1:0] privT;

  localparam privT PRIV_U = 2'd0;
  localparam privT PRIV_S = 2'd1;
  localparam privT PRIV_M = 2'd3;   // 2 is reserved

  //////////////////////////////
  // CSR address bases
  localparam logic [11:0] MHPMCOUNTER   = 12'hB00;
  localparam logic [11:0] MHPMCOUNTERH  = 12'hB80;
  localparam logic [11:0] HPMCOUNTER    = 12'hC00;
  localparam logic [11:0] HPMCOUNTERH   = 12'hC80;
  localparam logic [11:0] TIME          = 12'hC01;   // shadow of mtime
  localparam logic [11:0] TIMEH         = 12'hC81;   // rv32 only
  localparam logic [11:0] MCOUNTINHIBIT = 12'h320;
  localparam logic [11:0] MCOUNTEREN    = 12'h306;
  localparam logic [11:0] SCOUNTEREN    = 12'h106;

  //////////////////////////////
  // counter event slots
  localparam int EV_CYCLE      = 0;
  localparam int EV_INSTRET    = 2;
  localparam int EV_BRANCH     = 3;
  localparam int EV_JUMP       = 4;
  localparam int EV_RETURN     = 5;
  localparam int EV_BPWRONG    = 6;
  localparam int EV_LOADSTALL  = 7;
  localparam int EV_STORESTALL = 8;
  localparam int EV_DACCESS    = 9;
  localparam int EV_DMISS      = 10;
  localparam int EV_IACCESS    = 11;
  localparam int EV_IMISS      = 12;
  localparam int EV_EXCEPT     = 13;
  localparam int EV_INTERRUPT  = 14;

  // CSR address seen as a plain number or as its encoded fields
  typedef union packed {
    logic [11:0] raw;
    struct packed {
      logic [1:0] access;    // 2'b11 means read only
      logic [1:0] lowPriv;   // lowest mode allowed to touch it
      logic [7:0] index;
    } f;
  } csrAddrT;

endpackage
